//--- include/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// frame format, fixed at compile time
`define UART_DATA_WIDTH 8         // data bits per frame, sent lsb first
`define UART_PARITY_EN 1          // 1 adds a parity bit after the data
`define UART_PARITY_ODD 0         // 0 even parity, 1 odd parity

// sampling rates, all counted in tx_clk
`define UART_OVERSAMPLE 8         // receiver samples per bit
`define UART_CLKS_PER_SAMPLE 4    // tx_clk cycles per sample, so 32 per bit
`define UART_SYNC_STAGES 3        // flops on the receive line

// start + data + optional parity + stop
`define UART_FRAME_BITS (1 + `UART_DATA_WIDTH + `UART_PARITY_EN + 1)

`endif

//--- verilog/uart_frame_pkg.sv
`include "uart_params.svh"

package uart_frame_pkg;

	// one data word as it goes onto the line
	typedef logic [`UART_DATA_WIDTH-1:0] uart_data_t;

	// what the receiver reports for each frame
	typedef struct packed {
		uart_data_t data;    // received word, lsb first on the wire
		logic parity_err;    // parity bit disagreed with the configured parity
		logic stop_err;      // stop bit sampled low
	} uart_rx_result_t;

endpackage

//--- verilog/uart_state_pkg.sv
package uart_state_pkg;

	// transmit engine, one state per frame field
	typedef enum logic [2:0] {
		tx_idle   = 3'd0,    // line high, may hold a loaded frame waiting for a bit strobe
		tx_start  = 3'd1,    // start bit on the line
		tx_data   = 3'd2,    // data bits, counted separately
		tx_parity = 3'd3,    // parity bit on the line
		tx_stop   = 3'd4     // stop bit on the line
	} tx_state_t;

	// receive engine, states follow the field being sampled next
	typedef enum logic [2:0] {
		rx_idle   = 3'd0,    // waiting for a falling edge
		rx_start  = 3'd1,    // start bit, confirmed at its mid-sample
		rx_data   = 3'd2,    // data bits
		rx_parity = 3'd3,    // parity bit
		rx_stop   = 3'd4     // stop bit, result goes out here
	} rx_state_t;

endpackage

//--- verilog/uart_baud_gen.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_baud_gen (
	input  logic tx_clk,
	input  logic reset_tx,
	output logic o_sample_stb,   // one cycle every UART_CLKS_PER_SAMPLE cycles
	output logic o_bit_stb       // one cycle on every UART_OVERSAMPLE-th sample strobe
);

	localparam int CLK_W = (`UART_CLKS_PER_SAMPLE > 1) ? $clog2(`UART_CLKS_PER_SAMPLE) : 1;
	localparam int IDX_W = (`UART_OVERSAMPLE > 1) ? $clog2(`UART_OVERSAMPLE) : 1;
	localparam logic [CLK_W-1:0] CLK_LAST = CLK_W'(`UART_CLKS_PER_SAMPLE - 1);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`UART_OVERSAMPLE - 1);
	localparam int BIT_CLKS = `UART_CLKS_PER_SAMPLE * `UART_OVERSAMPLE;

	logic [CLK_W-1:0] clk_cnt;      // cycles inside one sample period
	logic [IDX_W-1:0] sample_idx;   // samples inside one bit period

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			clk_cnt      <= '0;
			sample_idx   <= '0;
			o_sample_stb <= 1'b0;   // strobes low on the first cycle
			o_bit_stb    <= 1'b0;
		end else begin
			o_sample_stb <= 1'b0;   // pulses only
			o_bit_stb    <= 1'b0;
			if (clk_cnt == CLK_LAST) begin
				clk_cnt      <= '0;
				o_sample_stb <= 1'b1;
				if (sample_idx == IDX_LAST) begin
					sample_idx <= '0;
					o_bit_stb  <= 1'b1;   // lines up with this sample strobe
				end else begin
					sample_idx <= sample_idx + 1'b1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// bit strobe rides on a sample strobe
	a_bit_on_sample : assert property (@(posedge tx_clk) disable iff (reset_tx)
		o_bit_stb |-> o_sample_stb);

	// bit strobes come exactly one bit period apart, the transmitter relies on it
	a_bit_period : assert property (@(posedge tx_clk) disable iff (reset_tx)
		o_bit_stb |=> !o_bit_stb [* (BIT_CLKS - 1)] ##1 o_bit_stb);

endmodule

//--- verilog/uart_tx.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx
	import uart_frame_pkg::*, uart_state_pkg::*;
(
	input  logic       tx_clk,
	input  logic       reset_tx,
	input  logic       i_bit_stb,      // one pulse per bit period
	input  logic       i_enable,       // taken only while o_busy is low
	input  uart_data_t i_data,
	output logic       o_serial_out,   // idles high
	output logic       o_busy
);

	localparam int FRAME_W = `UART_FRAME_BITS;
	localparam int CNT_W = (`UART_DATA_WIDTH > 1) ? $clog2(`UART_DATA_WIDTH) : 1;
	localparam logic [CNT_W-1:0] LAST_DATA = CNT_W'(`UART_DATA_WIDTH - 1);

	tx_state_t state;
	logic [CNT_W-1:0] bit_cnt;         // data bit being shifted
	logic [FRAME_W-1:0] shift_reg;     // frame, bit 0 goes out next
	logic [FRAME_W-1:0] frame_load;
	logic parity_bit;
	logic accept;

	assign accept = i_enable && !o_busy;   // enable while busy is dropped

	// even parity makes the ones count even, odd flips it
	assign parity_bit = (^i_data) ^ 1'b`UART_PARITY_ODD;

	always_comb begin
		frame_load = '1;                             // stop bit and anything above it
		frame_load[0] = 1'b0;                        // start bit
		frame_load[`UART_DATA_WIDTH:1] = i_data;     // lsb first after start
		if (`UART_PARITY_EN) begin
			frame_load[`UART_DATA_WIDTH+1] = parity_bit;
		end
	end

	// frame register, loaded on acceptance and shifted per bit
	always_ff @(posedge tx_clk) begin
		if (accept) begin
			shift_reg <= frame_load;
		end else if (i_bit_stb && (o_busy || state != tx_idle)) begin
			shift_reg <= {1'b1, shift_reg[FRAME_W-1:1]};   // fill with idle level
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state        <= tx_idle;
			bit_cnt      <= '0;
			o_serial_out <= 1'b1;
			o_busy       <= 1'b0;
		end else begin
			if (accept) begin
				o_busy <= 1'b1;   // rises the cycle after acceptance
			end
			if (i_bit_stb) begin
				case (state)
					tx_idle: begin
						if (o_busy) begin                 // frame waiting for its first strobe
							o_serial_out <= shift_reg[0];   // start bit
							state        <= tx_start;
						end
					end
					tx_start: begin
						o_serial_out <= shift_reg[0];     // data bit 0
						bit_cnt      <= '0;
						state        <= tx_data;
					end
					tx_data: begin
						o_serial_out <= shift_reg[0];
						if (bit_cnt == LAST_DATA) begin   // last data bit done, next is parity or stop
							state <= `UART_PARITY_EN ? tx_parity : tx_stop;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
					tx_parity: begin
						o_serial_out <= shift_reg[0];     // stop bit
						state        <= tx_stop;
					end
					tx_stop: begin
						o_busy <= 1'b0;                   // stop bit ends on this strobe
						state  <= tx_idle;
					end
					default: state <= tx_idle;
				endcase
			end
		end
	end

	// line sits at mark level between frames and during stop
	a_line_high : assert property (@(posedge tx_clk) disable iff (reset_tx)
		(state inside {tx_idle, tx_stop}) |-> o_serial_out);

	// busy holds through the payload of the frame
	a_busy_held : assert property (@(posedge tx_clk) disable iff (reset_tx)
		(state inside {tx_data, tx_parity}) |=> o_busy);

endmodule

//--- verilog/uart_rx.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx
	import uart_frame_pkg::*, uart_state_pkg::*;
(
	input  logic            tx_clk,
	input  logic            reset_tx,
	input  logic            i_sample_stb,   // UART_OVERSAMPLE pulses per bit
	input  logic            i_serial_in,    // asynchronous line
	output logic            o_rx_valid,     // one-cycle pulse per frame
	output uart_rx_result_t o_rx_result     // held until the next pulse
);

	localparam int SYNC = `UART_SYNC_STAGES;
	localparam int PH_W = (`UART_OVERSAMPLE > 1) ? $clog2(`UART_OVERSAMPLE) : 1;
	localparam int CNT_W = (`UART_DATA_WIDTH > 1) ? $clog2(`UART_DATA_WIDTH) : 1;
	localparam logic [PH_W-1:0] HALF_LAST = PH_W'(`UART_OVERSAMPLE / 2 - 1);
	localparam logic [PH_W-1:0] FULL_LAST = PH_W'(`UART_OVERSAMPLE - 1);
	localparam logic [CNT_W-1:0] LAST_DATA = CNT_W'(`UART_DATA_WIDTH - 1);

	rx_state_t state;
	logic [SYNC-1:0] sync_ff;     // synchronizer chain, msb is the safe copy
	logic line;                   // synchronized line
	logic line_q;                 // previous value, for edge detection
	logic start_edge;
	logic [PH_W-1:0] phase;       // sample strobes since the last mid-bit
	logic mid_hit;                // this strobe is a mid-bit sample
	logic [CNT_W-1:0] bit_cnt;
	uart_data_t shift_data;       // data bits arrive lsb first
	logic parity_err_q;
	logic parity_exp;

	assign line       = sync_ff[SYNC-1];
	assign start_edge = line_q && !line;   // falling edge at synchronizer output

	// half a bit after the edge for the start bit, a full bit after that
	assign mid_hit = i_sample_stb &&
		(phase == ((state == rx_start) ? HALF_LAST : FULL_LAST));

	// data is complete by the time the parity bit is sampled
	assign parity_exp = (^shift_data) ^ 1'b`UART_PARITY_ODD;

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			sync_ff <= '1;   // idle level, no false start out of reset
			line_q  <= 1'b1;
		end else begin
			sync_ff <= {sync_ff[SYNC-2:0], i_serial_in};
			line_q  <= line;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state      <= rx_idle;
			phase      <= '0;
			bit_cnt    <= '0;
			o_rx_valid <= 1'b0;
		end else begin
			o_rx_valid <= 1'b0;
			if (state == rx_idle) begin
				phase <= '0;                  // realign on every start bit
				if (start_edge) begin
					state <= rx_start;
				end
			end else if (i_sample_stb) begin
				phase <= mid_hit ? '0 : phase + 1'b1;
			end
			if (mid_hit) begin
				case (state)
					rx_start: begin
						if (line) begin               // high again, glitch
							state <= rx_idle;
						end else begin
							bit_cnt <= '0;
							state   <= rx_data;
						end
					end
					rx_data: begin
						if (bit_cnt == LAST_DATA) begin
							state <= `UART_PARITY_EN ? rx_parity : rx_stop;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
					rx_parity: state <= rx_stop;
					rx_stop: begin
						o_rx_valid <= 1'b1;           // mid-sample of stop bit
						state      <= rx_idle;
					end
					default: state <= rx_idle;
				endcase
			end
		end
	end

	// payload registers, written only at mid-bit samples
	always_ff @(posedge tx_clk) begin
		if (mid_hit) begin
			if (state == rx_data) begin
				shift_data <= {line, shift_data[`UART_DATA_WIDTH-1:1]};
			end
			if (state == rx_parity) begin
				parity_err_q <= line ^ parity_exp;
			end
			if (state == rx_stop) begin
				o_rx_result.data       <= shift_data;
				o_rx_result.parity_err <= `UART_PARITY_EN ? parity_err_q : 1'b0;
				o_rx_result.stop_err   <= !line;
			end
		end
	end

	// one frame cannot end twice in a row
	a_valid_pulse : assert property (@(posedge tx_clk) disable iff (reset_tx)
		o_rx_valid |=> !o_rx_valid);

endmodule

//--- verilog/uart_top.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_top
	import uart_frame_pkg::*;
(
	input  logic            tx_clk,
	input  logic            reset_tx,
	input  logic            i_enable,       // start a frame when not busy
	input  uart_data_t      i_data,
	input  logic            i_serial_in,    // receive line, looped back outside
	output logic            o_serial_out,   // transmit line
	output logic            o_busy,
	output logic            o_rx_valid,
	output uart_rx_result_t o_rx_result
);

	logic sample_stb;   // receiver oversampling
	logic bit_stb;      // transmitter bit timing

	uart_baud_gen i_uart_baud_gen (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.o_sample_stb (sample_stb),
		.o_bit_stb    (bit_stb)
	);

	uart_tx i_uart_tx (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.i_bit_stb    (bit_stb),
		.i_enable     (i_enable),
		.i_data       (i_data),
		.o_serial_out (o_serial_out),
		.o_busy       (o_busy)
	);

	// receiver keeps its own phase, only the sample rate is shared
	uart_rx i_uart_rx (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.i_sample_stb (sample_stb),
		.i_serial_in  (i_serial_in),
		.o_rx_valid   (o_rx_valid),
		.o_rx_result  (o_rx_result)
	);

endmodule

//--- verif/uart_tb.sv
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tb
	import uart_frame_pkg::*;
;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	localparam int BIT_CLKS = `UART_OVERSAMPLE * `UART_CLKS_PER_SAMPLE;   // 32 cycles per bit
	localparam int FRAME_W = `UART_FRAME_BITS;
	localparam int N_ROWS = 12;
	localparam int WATCHDOG_CYCLES = 2 * N_ROWS * (`UART_FRAME_BITS + 2) * BIT_CLKS;

	typedef enum logic [1:0] {
		mode_loop,          // tx looped back into rx
		mode_bad_parity,    // injected frame with the parity bit flipped
		mode_bad_stop,      // injected frame with a low stop bit
		mode_busy_enable    // second enable while the first frame is on the line
	} mode_t;

	typedef struct packed {
		uart_data_t data;
		mode_t mode;
		logic exp_parity_err;
		logic exp_stop_err;
	} row_t;

	logic tx_clk = 1'b0;
	logic reset_tx;
	logic i_enable;
	uart_data_t i_data;
	logic i_serial_in = 1'b1;   // line idles high
	logic o_serial_out;
	logic o_busy;
	logic o_rx_valid;
	uart_rx_result_t o_rx_result;

	logic loop_en = 1'b1;        // 1 routes o_serial_out back to i_serial_in
	logic inject_level = 1'b1;   // line level while injecting
	row_t stim_table [N_ROWS];
	uart_rx_result_t rx_q [$];   // results seen by the monitor, in order
	int checks = 0;
	int value_errs = 0;
	int other_errs = 0;

	uart_top i_uart_top (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.i_enable     (i_enable),
		.i_data       (i_data),
		.i_serial_in  (i_serial_in),
		.o_serial_out (o_serial_out),
		.o_busy       (o_busy),
		.o_rx_valid   (o_rx_valid),
		.o_rx_result  (o_rx_result)
	);

	initial begin
		forever #(CLK_PERIOD / 2) tx_clk = ~tx_clk;
	end

	// receive line follows the transmit line or the injected level on falling edges
	always @(negedge tx_clk) begin
		i_serial_in <= loop_en ? o_serial_out : inject_level;
	end

	// collect every valid pulse in arrival order
	always @(negedge tx_clk) begin
		if (o_rx_valid === 1'b1) begin
			rx_q.push_back(o_rx_result);
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// expected flags follow from how the row corrupts the frame
	function automatic row_t make_row(uart_data_t d, mode_t m);
		row_t r;
		r.data = d;
		r.mode = m;
		r.exp_parity_err = (m == mode_bad_parity) && (`UART_PARITY_EN != 0);
		r.exp_stop_err = (m == mode_bad_stop);
		return r;
	endfunction

	// start low, data lsb first, parity from the ones count, stop high
	function automatic logic [FRAME_W-1:0] build_frame(uart_data_t d);
		logic [FRAME_W-1:0] f;
		int ones;
		ones = 0;
		f = '1;
		f[0] = 1'b0;
		for (int i = 0; i < `UART_DATA_WIDTH; i++) begin
			f[i+1] = d[i];
			ones += d[i];
		end
		if (`UART_PARITY_EN != 0) begin
			f[`UART_DATA_WIDTH+1] = ((ones % 2) == 1) ^ (`UART_PARITY_ODD != 0);
		end
		return f;
	endfunction

	task automatic check_value(string name, logic [15:0] exp, logic [15:0] act, int row);
		checks++;
		assert (act === exp) else begin
			$display("Error: %s expected 0x%h got 0x%h (row %0d)", name, exp, act, row);
			value_errs++;
		end
	endtask

	task automatic check_idle_outputs(int row);
		check_value("o_serial_out", 16'h1, o_serial_out, row);
		check_value("o_busy", 16'h0, o_busy, row);
		check_value("o_rx_valid", 16'h0, o_rx_valid, row);
	endtask

	// enable on the first falling edge with o_busy low and expect busy on the next
	task automatic send_byte(uart_data_t d, int row);
		while (o_busy === 1'b1) @(negedge tx_clk);
		i_enable = 1'b1;
		i_data   = d;
		@(negedge tx_clk);
		i_enable = 1'b0;
		check_value("o_busy", 16'h1, o_busy, row);   // rose after acceptance
	endtask

	// follow the line from its falling edge and look once per mid-bit
	task automatic check_wave(uart_data_t d, int row);
		logic [FRAME_W-1:0] f;
		int t;
		int i;
		f = build_frame(d);
		t = 0;
		while (o_serial_out === 1'b1 && t < 2 * BIT_CLKS) begin
			@(negedge tx_clk);
			t++;
		end
		assert (o_serial_out === 1'b0) else begin
			$display("row %0d: no start bit appeared on the transmit line", row);
			other_errs++;
		end
		if (o_serial_out === 1'b0) begin
			repeat (BIT_CLKS / 2) @(negedge tx_clk);   // to mid start bit
			for (i = 0; i < FRAME_W; i++) begin
				if (i > 0) begin
					repeat (BIT_CLKS) @(negedge tx_clk);
				end
				check_value("o_serial_out", f[i], o_serial_out, row);
				check_value("o_busy", 16'h1, o_busy, row);
			end
			t = 0;
			while (o_busy === 1'b1 && t < BIT_CLKS) begin   // end of stop bit
				@(negedge tx_clk);
				t++;
			end
			assert (o_busy === 1'b0) else begin
				$display("row %0d: busy still high one bit after the stop mid-sample", row);
				other_errs++;
			end
		end
	endtask

	// offer another byte mid frame that must be ignored
	task automatic enable_while_busy(uart_data_t other, int row);
		repeat (3 * BIT_CLKS) @(negedge tx_clk);
		check_value("o_busy", 16'h1, o_busy, row);
		i_enable = 1'b1;
		i_data   = other;
		@(negedge tx_clk);
		i_enable = 1'b0;
	endtask

	// drive a whole frame by hand at 32 cycles per bit
	task automatic inject_frame(uart_data_t d, mode_t m);
		logic [FRAME_W-1:0] f;
		int i;
		f = build_frame(d);
		if (m == mode_bad_parity && `UART_PARITY_EN != 0) begin
			f[`UART_DATA_WIDTH+1] = ~f[`UART_DATA_WIDTH+1];
		end
		if (m == mode_bad_stop) begin
			f[FRAME_W-1] = 1'b0;
		end
		for (i = 0; i < FRAME_W; i++) begin
			inject_level <= f[i];
			repeat (BIT_CLKS) @(negedge tx_clk);
		end
		inject_level <= 1'b1;                      // back to idle
		repeat (2 * BIT_CLKS) @(negedge tx_clk);
	endtask

	task automatic pop_result(row_t r, int row);
		uart_rx_result_t res;
		int t;
		t = 0;
		while (rx_q.size() == 0 && t < 2 * BIT_CLKS) begin
			@(negedge tx_clk);
			t++;
		end
		assert (rx_q.size() > 0) else begin
			$display("row %0d: receiver gave no result", row);
			other_errs++;
		end
		if (rx_q.size() > 0) begin
			res = rx_q.pop_front();
			check_value("o_rx_result.data", r.data, res.data, row);
			check_value("o_rx_result.parity_err", r.exp_parity_err, res.parity_err, row);
			check_value("o_rx_result.stop_err", r.exp_stop_err, res.stop_err, row);
		end
		assert (rx_q.size() == 0) else begin
			$display("row %0d: receiver gave more than one result", row);
			other_errs++;
		end
	endtask

	task automatic run_row(row_t r, int row);
		case (r.mode)
			mode_loop: begin
				loop_en <= 1'b1;
				send_byte(r.data, row);
				check_wave(r.data, row);
			end
			mode_busy_enable: begin
				loop_en <= 1'b1;
				send_byte(r.data, row);
				fork
					check_wave(r.data, row);
					enable_while_busy(~r.data, row);
				join
				repeat (40) @(negedge tx_clk);
				check_value("o_busy", 16'h0, o_busy, row);   // second byte never started
			end
			default: begin
				loop_en <= 1'b0;
				inject_frame(r.data, r.mode);
			end
		endcase
		pop_result(r, row);
	endtask

	initial begin
		int r;
		void'($urandom(97579));
		reset_tx = 1'b1;
		i_enable = 1'b0;
		i_data   = '0;
		// rows 0 to 3 run back to back in loopback
		stim_table[0]  = make_row(8'h55, mode_loop);
		stim_table[1]  = make_row(8'h00, mode_loop);
		stim_table[2]  = make_row(8'hff, mode_loop);
		stim_table[3]  = make_row(uart_data_t'($urandom), mode_loop);
		stim_table[4]  = make_row(8'ha5, mode_bad_parity);
		stim_table[5]  = make_row(8'h3c, mode_bad_stop);
		stim_table[6]  = make_row(8'h81, mode_busy_enable);
		stim_table[7]  = make_row(uart_data_t'($urandom), mode_loop);
		stim_table[8]  = make_row(uart_data_t'($urandom), mode_loop);
		stim_table[9]  = make_row(uart_data_t'($urandom), mode_bad_parity);
		stim_table[10] = make_row(uart_data_t'($urandom), mode_bad_stop);
		stim_table[11] = make_row(uart_data_t'($urandom), mode_busy_enable);

		repeat (RESET_CYCLES) begin
			@(negedge tx_clk);
			check_idle_outputs(-1);
		end
		reset_tx = 1'b0;
		repeat (2) begin
			@(negedge tx_clk);
			check_idle_outputs(-1);   // still quiet just after reset
		end

		for (r = 0; r < N_ROWS; r++) begin
			run_row(stim_table[r], r);
		end

		repeat (2 * BIT_CLKS) @(negedge tx_clk);
		assert (rx_q.size() == 0) else begin
			$display("receiver gave %0d results nobody sent", rx_q.size());
			other_errs++;
		end

		$display("checks %0d, value errors %0d, other errors %0d", checks, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+include
verilog/uart_frame_pkg.sv
verilog/uart_state_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_top.sv
verif/uart_tb.sv
